//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lcd_ctrl
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST)) common/lcd_timing_macros.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- common/fb_pkg.sv
`include "lcd_timing_macros.svh"

package fb_pkg;

    localparam int ADDR_W = $clog2(`FB_DEPTH);

    // Cell index, row major
    typedef logic [ADDR_W-1:0] fb_addr_t;

    // RGB332 color, red in the top bits
    typedef logic [7:0] pixel_t;

    // One client access to the RAM port
    typedef struct packed {
        logic     req;
        logic     we;    // Write when set, else read
        fb_addr_t addr;
        pixel_t   wdata;
    } mem_req_t;

endpackage

//--- common/lcd_timing_macros.svh
`ifndef LCD_TIMING_MACROS_SVH
`define LCD_TIMING_MACROS_SVH

// Visible panel area
`define LCD_H_PIXELS 480
`define LCD_V_PIXELS 272

// Porches, in pixels and in lines
`define LCD_H_FRONT 2
`define LCD_H_BACK 2
`define LCD_V_FRONT 2
`define LCD_V_BACK 2

// Sync pulse widths
`define LCD_H_LOW 41 // Clock cycles
`define LCD_V_LOW 10 // Whole lines

// First active count and full period per axis
`define LCD_H_START (`LCD_H_LOW + `LCD_H_FRONT)
`define LCD_V_START (`LCD_V_LOW + `LCD_V_FRONT)
`define LCD_H_TOTAL (`LCD_H_START + `LCD_H_PIXELS + `LCD_H_BACK)
`define LCD_V_TOTAL (`LCD_V_START + `LCD_V_PIXELS + `LCD_V_BACK)

// Coarse frame buffer cells
`define LCD_CELL_SHIFT 3 // 8 by 8 pixels
`define LCD_CELLS_PER_ROW 60
`define FB_DEPTH 2048

`endif

//--- common/lcd_timing_pkg.sv
`include "lcd_timing_macros.svh"

package lcd_timing_pkg;

    // Wide enough for the longest period, 525 counts
    localparam int POS_W = $clog2(`LCD_H_TOTAL);

    // Pixel position or raw counter value
    typedef logic [POS_W-1:0] pos_t;

    // One pixel slot of the raster
    typedef struct packed {
        pos_t h_pos;      // Zero outside the active window
        pos_t v_pos;
        logic valid_draw; // Both axes active
        logic hsync;      // Active low
        logic vsync;      // Active low
    } raster_t;

endpackage

//--- flist.f
+incdir+common
common/lcd_timing_pkg.sv
common/fb_pkg.sv
timing/video_position_sync.sv
framebuffer/fb_ram.sv
framebuffer/fb_arbiter.sv
rtl/scanout.sv
rtl/host_port.sv
rtl/lcd_ctrl_top.sv
tests/tb_lcd_ctrl.sv

//--- framebuffer/fb_arbiter.sv
module fb_arbiter (
    input  logic             disp_clk,
    input  logic             rst_n,
    input  fb_pkg::mem_req_t scan_req,
    input  fb_pkg::mem_req_t host_req,
    output logic             host_grant,
    output fb_pkg::pixel_t   scan_data
);

    import fb_pkg::*;

    mem_req_t ram_req;
    pixel_t   ram_rd_data;
    logic     scan_rd_q; // Last cycle carried a scanout read

    // Scanout has fixed priority
    // Host only gets the port in an idle scanout cycle
    assign host_grant = host_req.req && !scan_req.req;
    assign ram_req    = scan_req.req ? scan_req : host_req;

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_rd_q <= 1'b0;
        end else begin
            scan_rd_q <= scan_req.req && !scan_req.we;
        end
    end

    // Steer read data back to its client
    assign scan_data = scan_rd_q ? ram_rd_data : '0;

    fb_ram i_fb_ram (
        .disp_clk (disp_clk),
        .mem      (ram_req),
        .rd_data  (ram_rd_data)
    );

endmodule

//--- framebuffer/fb_ram.sv
`include "lcd_timing_macros.svh"

module fb_ram (
    input  logic             disp_clk,
    input  fb_pkg::mem_req_t mem,
    output fb_pkg::pixel_t   rd_data
);

    import fb_pkg::*;

    pixel_t ram [`FB_DEPTH]; // One color per cell, no init

    // Single port, write or read per cycle
    always_ff @(posedge disp_clk) begin
        if (mem.req) begin
            if (mem.we) begin
                ram[mem.addr] <= mem.wdata;
            end else begin
                rd_data <= ram[mem.addr]; // Data one cycle later
            end
        end
    end

endmodule

//--- rtl/host_port.sv
module host_port (
    input  logic             disp_clk,
    input  logic             rst_n,
    input  logic             set_addr,
    input  fb_pkg::fb_addr_t addr,
    input  logic             wr_stb,
    input  fb_pkg::pixel_t   wdata,
    input  logic             host_grant,
    output logic             busy,
    output fb_pkg::mem_req_t host_req
);

    import fb_pkg::*;

    fb_addr_t addr_q; // Next cell to write
    pixel_t   data_q; // Pending write data
    logic     pend;   // Write waits for a grant

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            pend   <= 1'b0;
        end else begin
            if (pend && host_grant) begin
                pend   <= 1'b0;
                addr_q <= addr_q + 1'b1; // Wraps at 2048
            end else if (set_addr) begin
                addr_q <= addr;
            end
            if (wr_stb) begin
                pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge disp_clk) begin
        if (wr_stb) begin
            data_q <= wdata;
        end
    end

    assign busy = pend;

    // Always a write
    assign host_req = '{req: pend, we: 1'b1, addr: addr_q, wdata: data_q};

endmodule

//--- rtl/lcd_ctrl_top.sv
module lcd_ctrl_top (
    input  logic             disp_clk,
    input  logic             rst_n,
    input  logic             en,
    input  logic             set_addr,
    input  fb_pkg::fb_addr_t addr,
    input  logic             wr_stb,
    input  fb_pkg::pixel_t   wdata,
    output logic             busy,
    output logic             lcd_hsync,
    output logic             lcd_vsync,
    output logic             lcd_de,
    output fb_pkg::pixel_t   lcd_rgb
);

    import lcd_timing_pkg::*;
    import fb_pkg::*;

    raster_t  raster;     // Current pixel slot
    mem_req_t scan_req;
    mem_req_t host_req;
    logic     host_grant;
    pixel_t   scan_data;

    video_position_sync i_video_position_sync (
        .disp_clk (disp_clk),
        .rst_n    (rst_n),
        .en       (en),
        .raster   (raster)
    );

    scanout i_scanout (
        .disp_clk  (disp_clk),
        .rst_n     (rst_n),
        .raster    (raster),
        .scan_req  (scan_req),
        .scan_data (scan_data),
        .lcd_hsync (lcd_hsync),
        .lcd_vsync (lcd_vsync),
        .lcd_de    (lcd_de),
        .lcd_rgb   (lcd_rgb)
    );

    host_port i_host_port (
        .disp_clk   (disp_clk),
        .rst_n      (rst_n),
        .set_addr   (set_addr),
        .addr       (addr),
        .wr_stb     (wr_stb),
        .wdata      (wdata),
        .host_grant (host_grant),
        .busy       (busy),
        .host_req   (host_req)
    );

    fb_arbiter i_fb_arbiter (
        .disp_clk   (disp_clk),
        .rst_n      (rst_n),
        .scan_req   (scan_req),
        .host_req   (host_req),
        .host_grant (host_grant),
        .scan_data  (scan_data)
    );

endmodule

//--- rtl/scanout.sv
`include "lcd_timing_macros.svh"

module scanout (
    input  logic                    disp_clk,
    input  logic                    rst_n,
    input  lcd_timing_pkg::raster_t raster,
    output fb_pkg::mem_req_t        scan_req,
    input  fb_pkg::pixel_t          scan_data,
    output logic                    lcd_hsync,
    output logic                    lcd_vsync,
    output logic                    lcd_de,
    output fb_pkg::pixel_t          lcd_rgb
);

    import lcd_timing_pkg::*;
    import fb_pkg::*;

    // Panel control levels, delayed as a group
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } lcd_ctl_t;

    pos_t     cell_x;
    pos_t     cell_y;
    fb_addr_t cell_addr;
    logic     cell_start; // First pixel of a cell row
    logic     rd_pend;    // Read issued last cycle
    pixel_t   color_q;    // Held for 8 pixels
    lcd_ctl_t ctl_d1;
    lcd_ctl_t ctl_d2;

    assign cell_x    = raster.h_pos >> `LCD_CELL_SHIFT;
    assign cell_y    = raster.v_pos >> `LCD_CELL_SHIFT;
    assign cell_addr = fb_addr_t'(cell_y * `LCD_CELLS_PER_ROW + cell_x); // Max 2039

    assign cell_start = raster.valid_draw &&
                        (raster.h_pos[`LCD_CELL_SHIFT-1:0] == '0);

    // Read only, issued in the raster slot itself
    always_comb begin
        scan_req      = '0;
        scan_req.req  = cell_start;
        scan_req.addr = cell_addr;
    end

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            ctl_d1  <= '0;
            ctl_d2  <= '0;
        end else begin
            rd_pend <= cell_start;
            ctl_d1  <= '{hsync: raster.hsync, vsync: raster.vsync, de: raster.valid_draw};
            ctl_d2  <= ctl_d1; // Second stage meets the color
        end
    end

    // RAM data valid in the cycle after the read
    always_ff @(posedge disp_clk) begin
        if (rd_pend) begin
            color_q <= scan_data;
        end
    end

    assign lcd_hsync = ctl_d2.hsync;
    assign lcd_vsync = ctl_d2.vsync;
    assign lcd_de    = ctl_d2.de;
    assign lcd_rgb   = ctl_d2.de ? color_q : '0; // Black outside the window

endmodule

//--- tests/lcd_vectors.txt
# A addr (hex cell address), W data (hex RGB332), auto increment after each W
# P x y color (x, y decimal pixel, color hex) expected on the panel
A 000
W a1
W b2
W c3
A 03d
W 1c
A 7f7
W e0
A 4b0
W 3f
W 07
P 0 0 a1
P 13 5 b2
P 23 7 c3
P 8 8 1c
P 479 271 e0
P 2 160 3f
P 15 167 07

//--- tests/tb_lcd_ctrl.sv
module tb_lcd_ctrl;

    import lcd_timing_pkg::*;
    import fb_pkg::*;

    logic     disp_clk;
    logic     rst_n;
    logic     en;
    logic     set_addr;
    fb_addr_t addr;
    logic     wr_stb;
    pixel_t   wdata;
    logic     busy;
    logic     lcd_hsync;
    logic     lcd_vsync;
    logic     lcd_de;
    pixel_t   lcd_rgb;

    byte      cmd_kind [$]; // 'A' or 'W' in file order
    int       cmd_val  [$];
    int       p_cell   [$]; // Cells named by P lines
    pixel_t   exp_mem  [int]; // Expected color per checked cell
    logic     loaded = 1'b0;
    logic     check_on = 1'b0;
    int       seed = 32'h8a09;
    event     frame_start;

    // Raster tracker state
    pos_t x_cnt;    // De cycles in this line
    pos_t y_cnt;    // De lines since vsync fell
    pos_t h_per;    // Cycles since hsync fell
    pos_t h_low;
    pos_t v_per;    // Lines since vsync fell
    pos_t v_low;
    logic prev_hs;
    logic prev_vs;
    logic prev_de;
    logic h_seen;
    logic v_seen;
    int   pix_cell; // Cell under the tracked pixel

    lcd_ctrl_top i_lcd_ctrl_top (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_t act, input pixel_t exp);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_run("pixel color mismatch");
        end
    endtask

    task automatic check_pos(input string name, input pos_t act, input pos_t exp);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run("count mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
            stop_run("level mismatch");
        end
    endtask

    task automatic check_idle();
        check_level("lcd_hsync", lcd_hsync, 1'b0);
        check_level("lcd_vsync", lcd_vsync, 1'b0);
        check_level("lcd_de", lcd_de, 1'b0);
        check_pixel("lcd_rgb", lcd_rgb, 8'h00);
    endtask

    // Pulse one host strobe and wait for the write to retire
    task automatic host_cmd(input byte kind, input int val);
        int n;
        n = 0;
        @(posedge disp_clk);
        #1;
        if (kind == "A") begin
            set_addr = 1'b1;
            addr     = fb_addr_t'(val);
        end else begin
            wr_stb = 1'b1;
            wdata  = pixel_t'(val);
        end
        @(posedge disp_clk);
        #1;
        set_addr = 1'b0;
        wr_stb   = 1'b0;
        if (kind == "W") begin
            @(negedge disp_clk);
            while (busy) begin
                n++;
                if (n > 3) stop_run("busy did not clear within 3 cycles of a write");
                @(negedge disp_clk);
            end
        end
    endtask

    task automatic read_vectors();
        int            fd;
        int            r;
        int            v;
        int            x;
        int            y;
        logic [127:0]  tok;
        logic [1023:0] line;
        fd = $fopen("tests/lcd_vectors.txt", "r");
        if (fd == 0) stop_run("cannot open tests/lcd_vectors.txt");
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            if (tok[7:0] == "#") begin
                r = $fgets(line, fd); // Comment line
            end else if (tok[7:0] == "P") begin
                r = $fscanf(fd, "%d %d %h", x, y, v);
                p_cell.push_back((y >> 3) * 60 + (x >> 3));
                exp_mem[(y >> 3) * 60 + (x >> 3)] = pixel_t'(v);
            end else begin
                r = $fscanf(fd, "%h", v);
                cmd_kind.push_back(tok[7:0]);
                cmd_val.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        disp_clk = 1'b0;
        forever #5 disp_clk = ~disp_clk;
    end

    // Tracker samples on the falling edge
    always @(negedge disp_clk) begin
        if (!rst_n || !en) begin
            {x_cnt, y_cnt, h_per, h_low, v_per, v_low} = '0;
            {prev_hs, prev_vs, prev_de, h_seen, v_seen} = '0;
        end else begin
            if (prev_vs && !lcd_vsync) begin // Frame start
                if (v_seen) check_pos("vsync period lines", v_per, pos_t'(286));
                if (v_seen) check_pos("de lines per frame", y_cnt, pos_t'(272));
                v_seen = 1'b1;
                v_per  = '0;
                v_low  = '0;
                y_cnt  = '0;
                -> frame_start;
            end
            if (!prev_vs && lcd_vsync && v_seen) check_pos("vsync low lines", v_low, pos_t'(10));
            if (prev_hs && !lcd_hsync) begin // Line start
                if (h_seen) check_pos("hsync period", h_per, pos_t'(525));
                h_seen = 1'b1;
                h_per  = pos_t'(1);
                h_low  = pos_t'(1);
                v_per  = v_per + 1'b1;
                if (!lcd_vsync) v_low = v_low + 1'b1;
            end else begin
                h_per = h_per + 1'b1;
                if (!lcd_hsync) h_low = h_low + 1'b1;
            end
            if (!prev_hs && lcd_hsync && h_seen) check_pos("hsync low cycles", h_low, pos_t'(41));
            if (lcd_de) begin
                pix_cell = int'(y_cnt >> 3) * 60 + int'(x_cnt >> 3);
                if (check_on && exp_mem.exists(pix_cell)) begin
                    check_pixel("lcd_rgb", lcd_rgb, exp_mem[pix_cell]);
                end
                x_cnt = x_cnt + 1'b1;
            end else begin
                check_pixel("lcd_rgb", lcd_rgb, 8'h00); // Black outside window
            end
            if (prev_de && !lcd_de) begin // End of a drawn line
                check_pos("de cycles per line", x_cnt, pos_t'(480));
                x_cnt = '0;
                y_cnt = y_cnt + 1'b1;
            end
            prev_hs = lcd_hsync;
            prev_vs = lcd_vsync;
            prev_de = lcd_de;
        end
    end

    // Watchdog allows four frames plus one frame per host command
    initial begin
        wait (loaded);
        #((64'd4 + cmd_kind.size()) * 525 * 286 * 10);
        $display("Timeout, the test did not finish in the expected time");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        rst_n    = 1'b0;
        en       = 1'b0;
        set_addr = 1'b0;
        addr     = '0;
        wr_stb   = 1'b0;
        wdata    = '0;
        read_vectors();
        loaded = 1'b1;
        repeat (4) begin
            @(negedge disp_clk);
            check_idle();
            check_level("busy", busy, 1'b0);
        end
        @(posedge disp_clk);
        #1 rst_n = 1'b1;
        // Writes with the display disabled
        foreach (cmd_kind[i]) host_cmd(cmd_kind[i], cmd_val[i]);
        @(negedge disp_clk);
        check_idle();
        @(posedge disp_clk);
        #1 en = 1'b1;
        repeat (3) begin // Line 0 starts inside both sync pulses
            @(negedge disp_clk);
            check_level("lcd_hsync", lcd_hsync, 1'b0);
            check_level("lcd_vsync", lcd_vsync, 1'b0);
        end
        check_on = 1'b1;
        @(frame_start); // First frame checked
        @(frame_start); // Second frame adds the geometry checks
        // New colors written while pixels are drawn
        check_on = 1'b0;
        wait (lcd_de);
        foreach (p_cell[i]) begin
            exp_mem[p_cell[i]] = pixel_t'($random(seed));
            host_cmd("A", p_cell[i]);
            host_cmd("W", int'(exp_mem[p_cell[i]]));
        end
        @(frame_start);
        check_on = 1'b1;
        @(frame_start);
        // Drop en in the middle of the frame
        wait (y_cnt == pos_t'(100));
        @(posedge disp_clk);
        #1 en = 1'b0;
        repeat (3) @(negedge disp_clk);
        repeat (20) begin
            @(negedge disp_clk);
            check_idle();
        end
        @(posedge disp_clk);
        #1 en = 1'b1;
        @(frame_start);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- timing/video_position_sync.sv
`include "lcd_timing_macros.svh"

module video_position_sync (
    input  logic                    disp_clk,
    input  logic                    rst_n,
    input  logic                    en,
    output lcd_timing_pkg::raster_t raster
);

    import lcd_timing_pkg::*;

    pos_t    h_count; // Counts 0 to 524
    pos_t    v_count; // Lines 0 to 285
    logic    h_last;
    logic    v_last;
    logic    h_act;
    logic    v_act;
    raster_t next_raster;

    assign h_last = (h_count == pos_t'(`LCD_H_TOTAL - 1));
    assign v_last = (v_count == pos_t'(`LCD_V_TOTAL - 1));

    // Active window, counts 43..522 and lines 12..283
    assign h_act = (h_count >= pos_t'(`LCD_H_START)) &&
                   (h_count < pos_t'(`LCD_H_START + `LCD_H_PIXELS));
    assign v_act = (v_count >= pos_t'(`LCD_V_START)) &&
                   (v_count < pos_t'(`LCD_V_START + `LCD_V_PIXELS));

    // Decode of the current counts
    // Positions line up with valid_draw in the same slot
    always_comb begin
        next_raster       = '0;
        next_raster.hsync = (h_count >= pos_t'(`LCD_H_LOW)); // Low during pulse
        next_raster.vsync = (v_count >= pos_t'(`LCD_V_LOW));
        if (h_act && v_act) begin
            next_raster.valid_draw = 1'b1;
            next_raster.h_pos      = h_count - pos_t'(`LCD_H_START);
            next_raster.v_pos      = v_count - pos_t'(`LCD_V_START);
        end
    end

    always_ff @(posedge disp_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
            raster  <= '0;
        end else if (!en) begin // Held idle, frame restarts at count 0
            h_count <= '0;
            v_count <= '0;
            raster  <= '0;
        end else begin
            raster <= next_raster;
            if (h_last) begin
                h_count <= '0;
                if (v_last) begin // End of frame
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

endmodule
